/* soc_ctrl.f */
logic/soc_pkg.sv
logic/pi_bus_if.sv
logic/pi_router.sv
logic/dev_table.sv
logic/reset_seq.sv
logic/scratch_ram.sv
logic/soc_ctrl_top.sv
tests/tb_clock.sv
tests/soc_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SoC control plane testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module soc_ctrl_tb \
	-Mdir obj_dir -f soc_ctrl.f
out=$(./obj_dir/Vsoc_ctrl_tb)
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1

/* tests/soc_ctrl_tb.sv */
/*
 * Testbench for the SoC control plane
 * Four-phase bus transfers against the device table, scratch RAM, invalid
 * device and the reset sequencer
 */
`timescale 1ns/1ns

module soc_ctrl_tb;

	localparam int          RST_CYCLES   = 16;
	localparam int          RAM_WORDS    = 64;
	localparam logic [15:0] SCRATCH_BASE = 16'h0100;
	localparam logic [15:0] RST_REQ_ADDR = 16'h0001;
	// Five passes over the scratch RAM plus table, invalid and control transfers
	localparam int          XFER_COUNT   = 5 * RAM_WORDS + 80;
	localparam int          XFER_CYCLES  = 10;
	localparam int          WATCHDOG_CYC = XFER_COUNT * XFER_CYCLES + 8 * RST_CYCLES
		+ 2 * RAM_WORDS + 100;

	logic        clk24mhz;
	logic        rst_p;
	logic        extra_rst;
	logic        req;
	logic        we;
	logic [15:0] addr;
	logic [31:0] wdata;
	logic        ack;
	logic [31:0] rdata;
	logic        sys_rst;

	logic [31:0] model [RAM_WORDS];
	logic [15:0] lfsr_state = 16'd49182;
	int          cyc = 0;
	int          ack_cyc = 0;
	logic        rst_at_ack = 1'b0;
	logic        prev_ack = 1'b0;
	logic        prev_req = 1'b0;
	int          value_errs = 0;
	int          hs_errs = 0;

	tb_clock #(
		.RST_LEN (10)
	) tb_clock_inst (
		.rst_req_i (extra_rst),
		.clk_o     (clk24mhz),
		.rst_o     (rst_p)
	);

	soc_ctrl_top #(
		.RST_CYCLES (RST_CYCLES),
		.RAM_WORDS  (RAM_WORDS)
	) soc_ctrl_top_inst (
		.clk24mhz  (clk24mhz),
		.rst_p     (rst_p),
		.req_i     (req),
		.we_i      (we),
		.addr_i    (addr),
		.wdata_i   (wdata),
		.ack_o     (ack),
		.rdata_o   (rdata),
		.sys_rst_o (sys_rst)
	);

	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			value_errs++;
			$display("ERR %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// One four-phase transfer, starting and ending on a falling edge
	task automatic run_xfer(input logic write, input logic [15:0] a, input logic [31:0] d,
			output logic [31:0] q);
		@(negedge clk24mhz);
		req   = 1'b1;
		we    = write;
		addr  = a;
		wdata = d;
		while (!ack)
			@(negedge clk24mhz);
		ack_cyc    = cyc;
		rst_at_ack = sys_rst;
		q          = rdata;
		req        = 1'b0;
		while (ack)
			@(negedge clk24mhz);
	endtask

	task automatic write_word(input logic [15:0] a, input logic [31:0] d);
		logic [31:0] unused;
		run_xfer(1'b1, a, d, unused);
	endtask

	task automatic read_expect(input logic [15:0] a, input logic [31:0] exp, input string what);
		logic [31:0] q;
		run_xfer(1'b0, a, 32'd0, q);
		check_value($sformatf("%s, word %h", what, a), q, exp);
	endtask

	task automatic verify_scratch(input string what);
		for (int i = 0; i < RAM_WORDS; i++)
			read_expect(SCRATCH_BASE + 16'(i), model[i], what);
	endtask

	task automatic wait_sys_rst_low(output int fall_cyc);
		while (sys_rst)
			@(negedge clk24mhz);
		fall_cyc = cyc;
	endtask

	// System reset must already be up at ack_o and hold for the full count
	task automatic check_reset_pulse(input string what);
		int fall_cyc;
		check_value({what, ": sys_rst_o at ack_o"}, 32'(rst_at_ack), 32'd1);
		wait_sys_rst_low(fall_cyc);
		check_value({what, ": sys_rst_o hold cycles"}, fall_cyc - ack_cyc, RST_CYCLES);
	endtask

	// Handshake rules on values sampled at each rising edge
	always @(posedge clk24mhz) begin
		cyc <= cyc + 1;
		if (!rst_p) begin
			assert (prev_req || !(ack && !prev_ack)) else begin
				hs_errs++;
				$display("Handshake error at %0t ns: ack_o rose without a request", $time);
			end
			assert (prev_req || !prev_ack || !ack) else begin
				hs_errs++;
				$display("Handshake error at %0t ns: ack_o stayed high after req_i fell", $time);
			end
		end
		prev_ack <= ack;
		prev_req <= req;
	end

	initial begin
		repeat (WATCHDOG_CYC) @(posedge clk24mhz);
		$display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYC);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		int          start_cyc;
		int          fall_cyc;
		logic [31:0] d;
		logic [15:0] off;
		req       = 1'b0;
		we        = 1'b0;
		addr      = '0;
		wdata     = '0;
		extra_rst = 1'b0;

		@(negedge rst_p);
		start_cyc = cyc;
		check_value("ack_o after reset", 32'(ack), 32'd0);
		wait_sys_rst_low(fall_cyc);
		check_value("sys_rst_o hold after power-on", fall_cyc - start_cyc, RST_CYCLES);

		read_expect(16'h0000, 32'd6, "SoC id");
		read_expect(16'h0001, 32'd0, "reset request");
		read_expect(16'h0002, 32'd7, "device table id");
		read_expect(16'h0003, 32'd256, "device table size");
		read_expect(16'h0004, 32'd1, "scratch id");
		read_expect(16'h0005, 32'(RAM_WORDS), "scratch size");
		read_expect(16'h0006, 32'd0, "invalid device id");
		read_expect(16'h0007, 32'd256, "invalid device size");
		read_expect(16'h0008, 32'd0, "unused table word");

		for (int i = 0; i < RAM_WORDS; i++) begin
			d = next_bits(32);
			write_word(SCRATCH_BASE + 16'(i), d);
			model[i] = d;
		end
		// Offsets beyond the depth alias onto lower words
		for (int i = 0; i < 32; i++) begin
			off = 16'(next_bits(8));
			d = next_bits(32);
			write_word(SCRATCH_BASE + off, d);
			model[int'(off) % RAM_WORDS] = d;
		end
		verify_scratch("scratch readback");

		read_expect(16'h0200, 32'd0, "invalid device");
		read_expect(16'hffff, 32'd0, "invalid device");
		read_expect(16'h0200 + 16'(next_bits(15)), 32'd0, "invalid device");
		write_word(16'h0300, next_bits(32));
		read_expect(16'h0300, 32'd0, "invalid device after write");

		write_word(RST_REQ_ADDR, 32'd1);
		check_reset_pulse("warm reset");
		read_expect(RST_REQ_ADDR, 32'd0, "reset request after warm reset");
		verify_scratch("scratch after warm reset");

		write_word(RST_REQ_ADDR, 32'd2);
		check_reset_pulse("cold reset");
		for (int i = 0; i < RAM_WORDS; i++)
			model[i] = '0;
		read_expect(RST_REQ_ADDR, 32'd0, "reset request after cold reset");
		verify_scratch("scratch after cold reset");

		for (int i = 0; i < 8; i++) begin
			off = 16'(next_bits(6));
			d = next_bits(32);
			write_word(SCRATCH_BASE + off, d);
			model[int'(off)] = d;
		end

		// Power-off latches the system reset and stalls the master
		write_word(RST_REQ_ADDR, 32'd3);
		check_value("power-off: sys_rst_o at ack_o", 32'(rst_at_ack), 32'd1);
		@(negedge clk24mhz);
		req  = 1'b1;
		we   = 1'b0;
		addr = SCRATCH_BASE;
		repeat (4 * RST_CYCLES) begin
			@(negedge clk24mhz);
			check_value("power-off: sys_rst_o", 32'(sys_rst), 32'd1);
			assert (!ack) else begin
				hs_errs++;
				$display("Request acknowledged at %0t ns while powered off", $time);
			end
		end
		req       = 1'b0;
		extra_rst = 1'b1;
		repeat (10) @(negedge clk24mhz);
		extra_rst = 1'b0;
		start_cyc = cyc;
		wait_sys_rst_low(fall_cyc);
		check_value("sys_rst_o hold after external reset", fall_cyc - start_cyc, RST_CYCLES);
		read_expect(16'h0000, 32'd6, "SoC id after power-off");
		verify_scratch("scratch after power-off");

		$display("Value errors: %0d, handshake errors: %0d", value_errs, hs_errs);
		if (value_errs == 0 && hs_errs == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* tests/tb_clock.sv */
/*
 * Testbench clock and power-on reset
 * 20 ns clock, reset held for a number of cycles and re-assertable on request
 */
`timescale 1ns/1ns

module tb_clock #(
	parameter int RST_LEN = 10
) (
	input  logic rst_req_i,
	output logic clk_o,
	output logic rst_o
);
	logic por_q;

	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o;
	end

	// Released on a falling edge like the rest of the stimulus
	initial begin
		por_q = 1'b1;
		repeat (RST_LEN) @(posedge clk_o);
		@(negedge clk_o);
		por_q = 1'b0;
	end

	assign rst_o = por_q || rst_req_i;

endmodule

/* logic/soc_ctrl_top.sv */
/*
 * SoC control plane top level
 * Router, device table, scratch RAM and reset sequencer
 */
`timescale 1ns/1ns

module soc_ctrl_top #(
	parameter int RST_CYCLES = 16,
	parameter int RAM_WORDS  = 64
) (
	input  logic                       clk24mhz,
	input  logic                       rst_p,
	input  logic                       req_i,
	input  logic                       we_i,
	input  logic [soc_pkg::ADDR_W-1:0] addr_i,
	input  logic [soc_pkg::DATA_W-1:0] wdata_i,
	output logic                       ack_o,
	output logic [soc_pkg::DATA_W-1:0] rdata_o,
	output logic                       sys_rst_o
);
	import soc_pkg::*;

	rst_req_e rst_req;
	logic     sys_rst;
	logic     ram_clear;

	pi_bus_if devtbl_bus ();
	pi_bus_if ram_bus ();

	// Router sees only the outside reset so a stalled master survives a soft reset
	pi_router pi_router_inst (
		.clk24mhz   (clk24mhz),
		.rst_p      (rst_p),
		.sys_rst_i  (sys_rst),
		.req_i      (req_i),
		.we_i       (we_i),
		.addr_i     (addr_i),
		.wdata_i    (wdata_i),
		.ack_o      (ack_o),
		.rdata_o    (rdata_o),
		.devtbl_bus (devtbl_bus),
		.ram_bus    (ram_bus)
	);

	dev_table #(
		.RAM_WORDS (RAM_WORDS)
	) dev_table_inst (
		.clk24mhz  (clk24mhz),
		.sys_rst_i (sys_rst),
		.bus       (devtbl_bus),
		.rst_req_o (rst_req)
	);

	reset_seq #(
		.RST_CYCLES (RST_CYCLES)
	) reset_seq_inst (
		.clk24mhz    (clk24mhz),
		.rst_p       (rst_p),
		.rst_req_i   (rst_req),
		.sys_rst_o   (sys_rst),
		.ram_clear_o (ram_clear)
	);

	scratch_ram #(
		.RAM_WORDS (RAM_WORDS)
	) scratch_ram_inst (
		.clk24mhz    (clk24mhz),
		.sys_rst_i   (sys_rst),
		.ram_clear_i (ram_clear),
		.bus         (ram_bus)
	);

	assign sys_rst_o = sys_rst;

endmodule

/* logic/scratch_ram.sv */
/*
 * Scratch RAM
 * Word memory on the internal bus, walked to zero by a cold reset
 */
`timescale 1ns/1ns

module scratch_ram #(
	parameter int RAM_WORDS = 64
) (
	input  logic    clk24mhz,
	input  logic    sys_rst_i,
	input  logic    ram_clear_i,
	pi_bus_if.slave bus
);
	import soc_pkg::*;

	localparam int IDX_W = $clog2(RAM_WORDS);

	logic [DATA_W-1:0] mem [RAM_WORDS];
	logic [IDX_W-1:0]  word_idx;
	logic [IDX_W-1:0]  clr_idx;
	logic              clr_active;
	logic              access;

	assign word_idx = IDX_W'(bus.addr % RAM_WORDS);
	// Bus access waits until a clear walk has finished
	assign access   = (bus.op != OP_NONE) && !bus.rdy && !clr_active && !sys_rst_i;

	// The walk keeps going after the clear request drops, until it passes the last word
	always_ff @(posedge clk24mhz) begin
		if (ram_clear_i) begin
			if (!clr_active) begin
				clr_active <= 1'b1;
				clr_idx    <= '0;
			end else begin
				clr_idx <= (clr_idx == IDX_W'(RAM_WORDS - 1)) ? '0 : clr_idx + 1'b1;
			end
		end else if (sys_rst_i) begin
			clr_active <= 1'b0;
		end else if (clr_active) begin
			clr_idx <= clr_idx + 1'b1;
			if (clr_idx == IDX_W'(RAM_WORDS - 1))
				clr_active <= 1'b0;
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (sys_rst_i)
			bus.rdy <= 1'b0;
		else
			bus.rdy <= access;
	end

	always_ff @(posedge clk24mhz) begin
		if (clr_active)
			mem[clr_idx] <= '0;
		else if (access && bus.op == OP_WRITE)
			mem[word_idx] <= bus.wdata;
		if (access && bus.op == OP_READ)
			bus.rdata <= mem[word_idx];
	end

endmodule

/* logic/reset_seq.sv */
/*
 * Reset sequencer
 * Holds the system reset for a fixed count on power-on, warm and cold reset,
 * and latches it on power-off until the reset input returns
 */
`timescale 1ns/1ns

module reset_seq #(
	parameter int RST_CYCLES = 16
) (
	input  logic              clk24mhz,
	input  logic              rst_p,
	input  soc_pkg::rst_req_e rst_req_i,
	output logic              sys_rst_o,
	output logic              ram_clear_o
);
	import soc_pkg::*;

	localparam int CNT_W = $clog2(RST_CYCLES + 1);

	logic [CNT_W-1:0] cnt;
	logic             pwroff_q;
	logic             cold_q;

	always_ff @(posedge clk24mhz) begin
		if (rst_p) begin
			cnt      <= CNT_W'(RST_CYCLES);
			pwroff_q <= 1'b0;
			cold_q   <= 1'b0;
		end else begin
			case (rst_req_i)
				RST_WARM: cnt <= CNT_W'(RST_CYCLES);
				RST_COLD: begin
					cnt    <= CNT_W'(RST_CYCLES);
					cold_q <= 1'b1;
				end
				RST_PWROFF: pwroff_q <= 1'b1;
				default: begin
					if (cnt != '0)
						cnt <= cnt - 1'b1;
					else
						cold_q <= 1'b0;
				end
			endcase
		end
	end

	assign sys_rst_o   = (cnt != '0) || pwroff_q;
	// RAM clear only during a cold count
	assign ram_clear_o = cold_q && (cnt != '0);

endmodule

/* logic/dev_table.sv */
/*
 * Device table
 * Reports the SoC id, each device's id and map size, and holds the
 * software reset-request register
 */
`timescale 1ns/1ns

module dev_table #(
	parameter int RAM_WORDS = 64
) (
	input  logic               clk24mhz,
	input  logic               sys_rst_i,
	pi_bus_if.slave            bus,
	output soc_pkg::rst_req_e  rst_req_o
);
	import soc_pkg::*;

	localparam int OFF_W = $clog2(REGION_WORDS);

	// Same order as dev_e
	localparam logic [DATA_W-1:0] MAP_SZ [DEV_COUNT] = '{
		DATA_W'(REGION_WORDS),
		DATA_W'(RAM_WORDS),
		DATA_W'(REGION_WORDS)
	};

	rst_req_e          rst_req_q;
	logic [OFF_W-1:0]  word;
	logic [DATA_W-1:0] rd_val;
	dev_e              ent;
	logic              access;

	assign word   = bus.addr[OFF_W-1:0];
	assign access = (bus.op != OP_NONE) && !bus.rdy;

	// Words 2+2k and 3+2k describe device k
	assign ent = dev_e'(2'((word - OFF_W'(2)) >> 1));

	always_comb begin
		rd_val = '0;
		if (word == OFF_W'(0))
			rd_val = SOC_ID;
		else if (word == OFF_W'(1))
			rd_val = DATA_W'(rst_req_q);
		else if (word < OFF_W'(2 + 2 * DEV_COUNT))
			rd_val = word[0] ? MAP_SZ[ent] : DEV_ID[ent];
	end

	always_ff @(posedge clk24mhz) begin
		if (sys_rst_i) begin
			rst_req_q <= RST_NONE;
			bus.rdy   <= 1'b0;
		end else begin
			bus.rdy <= access;
			if (access && bus.op == OP_WRITE && word == OFF_W'(1))
				rst_req_q <= rst_req_e'(bus.wdata[1:0]);
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (access && bus.op == OP_READ)
			bus.rdata <= rd_val;
	end

	assign rst_req_o = rst_req_q;

endmodule

/* logic/pi_router.sv */
/*
 * Bus router
 * Turns the outside four-phase req/ack handshake into internal bus transfers
 * and decodes each word address to the device table, the scratch RAM or nothing
 */
`timescale 1ns/1ns

module pi_router (
	input  logic                       clk24mhz,
	input  logic                       rst_p,
	input  logic                       sys_rst_i,
	input  logic                       req_i,
	input  logic                       we_i,
	input  logic [soc_pkg::ADDR_W-1:0] addr_i,
	input  logic [soc_pkg::DATA_W-1:0] wdata_i,
	output logic                       ack_o,
	output logic [soc_pkg::DATA_W-1:0] rdata_o,
	pi_bus_if.master                   devtbl_bus,
	pi_bus_if.master                   ram_bus
);
	import soc_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		BUS,
		ACK,
		WAITDROP
	} state_e;

	state_e            state;
	logic              ack_q;
	logic              we_q;
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] wdata_q;
	logic [DATA_W-1:0] rdata_q;
	dev_e              dev_sel;
	pi_op_e            cur_op;
	logic              sel_rdy;

	function automatic dev_e decode(input logic [ADDR_W-1:0] a);
		logic [ADDR_W-1:0] off_tbl;
		logic [ADDR_W-1:0] off_ram;
		off_tbl = a - DEVTBL_BASE;
		off_ram = a - SCRATCH_BASE;
		if (off_tbl < ADDR_W'(REGION_WORDS))
			return DEV_DEVTBL;
		else if (off_ram < ADDR_W'(REGION_WORDS))
			return DEV_SCRATCH;
		else
			return DEV_INVALID;
	endfunction

	assign dev_sel = decode(addr_q);
	assign cur_op  = we_q ? OP_WRITE : OP_READ;

	// Only the selected target sees an opcode, and only while in BUS
	assign devtbl_bus.op    = (state == BUS && dev_sel == DEV_DEVTBL) ? cur_op : OP_NONE;
	assign devtbl_bus.addr  = addr_q;
	assign devtbl_bus.wdata = wdata_q;
	assign ram_bus.op       = (state == BUS && dev_sel == DEV_SCRATCH) ? cur_op : OP_NONE;
	assign ram_bus.addr     = addr_q;
	assign ram_bus.wdata    = wdata_q;

	always_comb begin
		case (dev_sel)
			DEV_DEVTBL:  sel_rdy = devtbl_bus.rdy;
			DEV_SCRATCH: sel_rdy = ram_bus.rdy;
			default:     sel_rdy = 1'b1;
		endcase
	end

	always_ff @(posedge clk24mhz) begin
		if (rst_p) begin
			state <= IDLE;
			ack_q <= 1'b0;
		end else begin
			case (state)
				// Requests wait here while the system is held in reset
				IDLE: if (req_i && !sys_rst_i) state <= BUS;
				BUS: if (sel_rdy) state <= ACK;
				ACK: begin
					ack_q <= 1'b1;
					state <= WAITDROP;
				end
				WAITDROP: if (!req_i) begin
					ack_q <= 1'b0;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (state == IDLE) begin
			we_q    <= we_i;
			addr_q  <= addr_i;
			wdata_q <= wdata_i;
		end
		if (state == BUS && sel_rdy) begin
			case (dev_sel)
				DEV_DEVTBL:  rdata_q <= devtbl_bus.rdata;
				DEV_SCRATCH: rdata_q <= ram_bus.rdata;
				// Invalid device reads as zero
				default:     rdata_q <= '0;
			endcase
		end
	end

	assign ack_o   = ack_q;
	assign rdata_o = rdata_q;

endmodule

/* logic/pi_bus_if.sv */
/*
 * Internal peripheral bus, one master and one slave per instance
 */
`timescale 1ns/1ns

interface pi_bus_if;
	import soc_pkg::*;

	pi_op_e            op;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic [DATA_W-1:0] rdata;
	// Single-cycle strobe from the slave when the transfer is done
	logic              rdy;

	modport master (
		output op, addr, wdata,
		input  rdata, rdy
	);

	modport slave (
		input  op, addr, wdata,
		output rdata, rdy
	);

endinterface

/* logic/soc_pkg.sv */
/*
 * SoC control plane package
 * Bus widths, word address map, device ids, bus opcodes and reset-request codes
 */
package soc_pkg;

	localparam int unsigned DATA_W = 32;
	localparam int unsigned ADDR_W = 16;

	// Every decoded region spans the same number of words
	localparam int unsigned REGION_WORDS = 256;

	localparam logic [ADDR_W-1:0] DEVTBL_BASE  = 16'h0000;
	localparam logic [ADDR_W-1:0] SCRATCH_BASE = 16'h0100;

	localparam logic [DATA_W-1:0] SOC_ID = 32'd6;

	// Targets behind the router, also the order of the device listing
	typedef enum logic [1:0] {
		DEV_DEVTBL,
		DEV_SCRATCH,
		DEV_INVALID
	} dev_e;

	localparam int unsigned DEV_COUNT = 3;

	// Indexed by dev_e
	localparam logic [DATA_W-1:0] DEV_ID [DEV_COUNT] = '{32'd7, 32'd1, 32'd0};

	typedef enum logic [1:0] {
		OP_NONE,
		OP_WRITE,
		OP_READ
	} pi_op_e;

	typedef enum logic [1:0] {
		RST_NONE,
		RST_WARM,
		RST_COLD,
		RST_PWROFF
	} rst_req_e;

endpackage
